//--- verilog/snd_map_pkg.sv
/*
 * sound CPU memory map
 * bus cycle struct, I/O page codes and PCM register offsets
 */
`default_nettype none

package snd_map_pkg;

    // one sound CPU bus cycle, strobes active high
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;   // cpu write data
        logic        mreq;
        logic        rfsh;   // high outside refresh
        logic        rd;
        logic        wr;
    } snd_bus_t;

    localparam logic [3:0] AF_PAGE = 4'hf;   // addr[15:12] of the I/O and RAM page

    // addr[11:9] inside the AF page
    localparam logic [2:0] IO_BANK   = 3'd7;
    localparam logic [2:0] IO_PCM    = 3'd6;
    localparam logic [2:0] IO_NMICLR = 3'd5;
    localparam logic [2:0] IO_FM     = 3'd4;

    localparam int BANK_W = 3;
    localparam int ROM_AW = 17;

    // PCM chip offsets on addr[2:0]
    localparam logic [2:0] PCM_L   = 3'd0;   // sample registers, write only
    localparam logic [2:0] PCM_R   = 3'd1;
    localparam logic [2:0] PCM_RX0 = 3'd2;   // from main CPU
    localparam logic [2:0] PCM_RX1 = 3'd3;
    localparam logic [2:0] PCM_TX0 = 3'd4;   // to main CPU
    localparam logic [2:0] PCM_TX1 = 3'd5;

endpackage

`default_nettype wire

//--- verilog/snd_mix_pkg.sv
/*
 * sound mixer definitions
 * sample widths, channel gains and the stereo pair struct
 */
`default_nettype none

package snd_mix_pkg;

    localparam int FM_W  = 16;
    localparam int PCM_W = 14;

    // gains are 4.4 fixed point, 8'h10 is unity
    localparam logic [7:0] FMGAIN = 8'h10;

    // pcm gain per fxlevel
    localparam logic [7:0] FXGAIN_0 = 8'h18;
    localparam logic [7:0] FXGAIN_1 = 8'h20;
    localparam logic [7:0] FXGAIN_2 = 8'h28;
    localparam logic [7:0] FXGAIN_3 = 8'h30;

    // stereo pair, pcm values arrive sign-extended to FM_W
    typedef struct packed {
        logic signed [FM_W-1:0] left;
        logic signed [FM_W-1:0] right;
    } mix_ch_t;

endpackage

`default_nettype wire

//--- verilog/snd_decode.sv
/*
 * sound CPU address decoder
 * chip selects, ROM bank register, read data mux and the NMI latch
 */
`default_nettype none
`timescale 1ns/1ps

module snd_decode (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire snd_map_pkg::snd_bus_t          bus,
    input  wire logic [7:0]                     rom_data,
    input  wire logic [7:0]                     tone_dout,
    input  wire logic [7:0]                     pcm_dout,
    input  wire logic                           sample,
    output logic      [7:0]                     cpu_din,
    output logic      [snd_map_pkg::ROM_AW-1:0] rom_addr,
    output logic                                rom_cs,
    output logic                                fm_cs,
    output logic                                pcm_cs,
    output logic                                nmi_n
);
    import snd_map_pkg::*;

    logic              mem_acc;
    logic              af;
    logic              bank_cs;
    logic              nmi_clr;
    logic [BANK_W-1:0] bank;

    // upper 32kB is banked, lower 32kB fixed at the start of the ROM
    assign rom_addr = {bus.addr[15] ? bank : {2'b00, bus.addr[14]}, bus.addr[13:0]};

    always_comb begin
        mem_acc = bus.mreq && bus.rfsh;
        af      = bus.addr[15:12] == AF_PAGE;
        rom_cs  = mem_acc && !af;
        bank_cs = 1'b0;
        pcm_cs  = 1'b0;
        nmi_clr = 1'b0;
        fm_cs   = 1'b0;
        if (mem_acc && af) begin
            case (bus.addr[11:9])
                IO_BANK:   bank_cs = 1'b1;
                IO_PCM:    pcm_cs  = 1'b1;
                IO_NMICLR: nmi_clr = bus.rd || bus.wr;   // any read or write
                IO_FM:     fm_cs   = 1'b1;
                default:   ;                             // work RAM window
            endcase
        end
    end

    always_comb begin
        if (rom_cs) begin
            cpu_din = rom_data;
        end else if (pcm_cs) begin
            cpu_din = pcm_dout;
        end else if (fm_cs) begin
            cpu_din = tone_dout;
        end else begin
            cpu_din = 8'hff;   // RAM window and open bus
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank  <= '0;
            nmi_n <= 1'b1;
        end else begin
            if (bank_cs && bus.wr) begin
                bank <= bus.dout[BANK_W-1:0];
            end
            // clear wins over a sample arriving in the same clk
            if (nmi_clr) begin
                nmi_n <= 1'b1;
            end else if (sample) begin
                nmi_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/snd_tone.sv
/*
 * FM stand-in
 * square tone with period and amplitude registers, one sample strobe per half wave
 */
`default_nettype none
`timescale 1ns/1ps

module snd_tone (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cen,
    input  wire logic                 cs,
    input  wire logic                 wr,
    input  wire logic                 a0,
    input  wire logic [7:0]           din,
    output logic      [7:0]           dout,
    output logic                      sample,
    output snd_mix_pkg::mix_ch_t      ch
);
    import snd_mix_pkg::*;

    logic [7:0]             period;
    logic [7:0]             amp;
    logic [7:0]             cnt;
    logic                   pol;
    logic signed [FM_W-1:0] amp_ext;
    logic signed [FM_W-1:0] tone;

    assign amp_ext = {1'b0, amp, 7'd0};   // amplitude << 7
    assign tone    = pol ? amp_ext : -amp_ext;
    assign ch      = '{left: tone, right: tone};
    assign dout    = {7'd0, pol};         // status, current polarity

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            period <= 8'hff;
            amp    <= 8'd0;
            cnt    <= 8'd0;
            pol    <= 1'b0;
            sample <= 1'b0;
        end else begin
            if (cs && wr) begin
                if (a0) begin
                    amp <= din;
                end else begin
                    period <= din;
                end
            end
            sample <= 1'b0;
            if (cen) begin
                if (cnt == period) begin
                    cnt    <= 8'd0;
                    pol    <= ~pol;
                    sample <= 1'b1;   // also drives the NMI
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/snd_pcm.sv
/*
 * PCM stand-in
 * direct stereo sample registers and the main/sound CPU latches
 */
`default_nettype none
`timescale 1ns/1ps

module snd_pcm (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            cs,
    input  wire logic            wr,
    input  wire logic [2:0]      addr,
    input  wire logic [7:0]      din,
    output logic      [7:0]      dout,
    input  wire logic            main_addr,
    input  wire logic            main_wr,
    input  wire logic [7:0]      main_dout,
    output logic      [7:0]      main_din,
    output snd_mix_pkg::mix_ch_t ch
);
    import snd_map_pkg::*;
    import snd_mix_pkg::*;

    logic signed [7:0]       smp_l;
    logic signed [7:0]       smp_r;
    logic signed [PCM_W-1:0] wide_l;
    logic signed [PCM_W-1:0] wide_r;
    logic [7:0]              rx [0:1];   // written by main CPU
    logic [7:0]              tx [0:1];   // written by sound CPU

    assign wide_l = {smp_l, 6'd0};
    assign wide_r = {smp_r, 6'd0};
    assign ch     = '{left: FM_W'(wide_l), right: FM_W'(wide_r)};   // sign extended

    assign main_din = tx[main_addr];

    always_comb begin
        case (addr)
            PCM_RX0: dout = rx[0];
            PCM_RX1: dout = rx[1];
            default: dout = 8'hff;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            smp_l <= '0;
            smp_r <= '0;
            rx[0] <= 8'd0;
            rx[1] <= 8'd0;
            tx[0] <= 8'd0;
            tx[1] <= 8'd0;
        end else begin
            if (main_wr) begin
                rx[main_addr] <= main_dout;
            end
            if (cs && wr) begin
                case (addr)
                    PCM_L:   smp_l <= din;
                    PCM_R:   smp_r <= din;
                    PCM_TX0: tx[0] <= din;
                    PCM_TX1: tx[1] <= din;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/snd_mixer.sv
/*
 * stereo output mixer
 * FM plus PCM with selectable gains, saturated to 16 bits
 */
`default_nettype none
`timescale 1ns/1ps

module snd_mixer (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cen,
    input  wire logic                 enable_fm,
    input  wire logic                 enable_psg,
    input  wire logic [1:0]           fxlevel,
    input  wire snd_mix_pkg::mix_ch_t fm,
    input  wire snd_mix_pkg::mix_ch_t pcm,
    output logic signed [15:0]        snd_l,
    output logic signed [15:0]        snd_r,
    output logic                      peak
);
    import snd_mix_pkg::*;

    logic [7:0]  fmgain;
    logic [7:0]  fxgain;
    logic [16:0] res_l;   // {saturated, sample}
    logic [16:0] res_r;

    // one side: weighted sum, /16 and clip
    function automatic logic [16:0] mix_side(input logic signed [15:0] a,
                                             input logic signed [15:0] b,
                                             input logic [7:0]         ga,
                                             input logic [7:0]         gb);
        logic signed [25:0] acc;
        logic signed [21:0] shr;
        acc = a * $signed({1'b0, ga}) + b * $signed({1'b0, gb});
        shr = acc[25:4];
        if (shr > 22'sd32767) begin
            return {1'b1, 16'h7fff};
        end else if (shr < -22'sd32768) begin
            return {1'b1, 16'h8000};
        end
        return {1'b0, shr[15:0]};
    endfunction

    assign res_l = mix_side(fm.left, pcm.left, fmgain, fxgain);
    assign res_r = mix_side(fm.right, pcm.right, fmgain, fxgain);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fmgain <= 8'd0;
            fxgain <= 8'd0;
            snd_l  <= '0;
            snd_r  <= '0;
            peak   <= 1'b0;
        end else begin
            fmgain <= enable_fm ? FMGAIN : 8'd0;
            case (fxlevel)
                2'd0: fxgain <= FXGAIN_0;
                2'd1: fxgain <= FXGAIN_1;
                2'd2: fxgain <= FXGAIN_2;
                2'd3: fxgain <= FXGAIN_3;
            endcase
            if (!enable_psg) begin
                fxgain <= 8'd0;   // pcm muted
            end
            if (cen) begin
                snd_l <= res_l[15:0];
                snd_r <= res_r[15:0];
                peak  <= res_l[16] | res_r[16];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/snd_board.sv
/*
 * arcade sound board
 * sound CPU decode, FM and PCM stand-ins and the output mixer
 */
`default_nettype none
`timescale 1ns/1ps

module snd_board (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           cen,
    input  wire logic                           enable_fm,
    input  wire logic                           enable_psg,
    input  wire logic [1:0]                     fxlevel,
    input  wire snd_map_pkg::snd_bus_t          bus,
    input  wire logic [7:0]                     rom_data,
    input  wire logic                           rom_ok,     // cpu wait lives outside
    output logic      [7:0]                     cpu_din,
    output logic      [snd_map_pkg::ROM_AW-1:0] rom_addr,
    output logic                                rom_cs,
    output logic                                nmi_n,
    input  wire logic                           main_addr,
    input  wire logic                           main_wr,
    input  wire logic [7:0]                     main_dout,
    output logic      [7:0]                     main_din,
    output logic signed [15:0]                  snd_l,
    output logic signed [15:0]                  snd_r,
    output logic                                sample,
    output logic                                peak
);
    import snd_mix_pkg::*;

    logic       fm_cs;
    logic       pcm_cs;
    logic [7:0] tone_dout;
    logic [7:0] pcm_dout;
    mix_ch_t    fm_ch;
    mix_ch_t    pcm_ch;

    snd_decode u_decode (
        .clk(clk), .rst(rst), .bus(bus),
        .rom_data(rom_data), .tone_dout(tone_dout), .pcm_dout(pcm_dout),
        .sample(sample), .cpu_din(cpu_din), .rom_addr(rom_addr),
        .rom_cs(rom_cs), .fm_cs(fm_cs), .pcm_cs(pcm_cs), .nmi_n(nmi_n)
    );

    snd_tone u_tone (
        .clk(clk), .rst(rst), .cen(cen), .cs(fm_cs), .wr(bus.wr),
        .a0(bus.addr[0]), .din(bus.dout), .dout(tone_dout),
        .sample(sample), .ch(fm_ch)
    );

    snd_pcm u_pcm (
        .clk(clk), .rst(rst), .cs(pcm_cs), .wr(bus.wr),
        .addr(bus.addr[2:0]), .din(bus.dout), .dout(pcm_dout),
        .main_addr(main_addr), .main_wr(main_wr), .main_dout(main_dout),
        .main_din(main_din), .ch(pcm_ch)
    );

    snd_mixer u_mixer (
        .clk(clk), .rst(rst), .cen(cen), .enable_fm(enable_fm),
        .enable_psg(enable_psg), .fxlevel(fxlevel), .fm(fm_ch), .pcm(pcm_ch),
        .snd_l(snd_l), .snd_r(snd_r), .peak(peak)
    );

endmodule

`default_nettype wire

//--- sim/snd_board_tb.sv
/*
 * sound board testbench
 * directed tests for banking, read mux, CPU latches, mixing, saturation and NMI
 */
`default_nettype none
`timescale 1ns/1ps

module snd_board_tb;
    import snd_map_pkg::*;
    import snd_mix_pkg::*;

    localparam snd_bus_t BUS_IDLE = '{addr: 16'h0000, dout: 8'h00, mreq: 1'b0,
                                      rfsh: 1'b1, rd: 1'b0, wr: 1'b0};

    logic               clk;
    logic               rst;
    logic               cen;
    logic               enable_fm;
    logic               enable_psg;
    logic [1:0]         fxlevel;
    snd_bus_t           bus;
    logic [7:0]         rom_data;
    logic               rom_ok;
    logic [7:0]         cpu_din;
    logic [ROM_AW-1:0]  rom_addr;
    logic               rom_cs;
    logic               nmi_n;
    logic               main_addr;
    logic               main_wr;
    logic [7:0]         main_dout;
    logic [7:0]         main_din;
    logic signed [15:0] snd_l;
    logic signed [15:0] snd_r;
    logic               sample;
    logic               peak;
    logic               read_cs;   // rom_cs seen by the last bus_read
    integer             seed;
    int                 errors;

    snd_board dut_i (
        .clk(clk), .rst(rst), .cen(cen), .enable_fm(enable_fm),
        .enable_psg(enable_psg), .fxlevel(fxlevel), .bus(bus),
        .rom_data(rom_data), .rom_ok(rom_ok), .cpu_din(cpu_din),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .nmi_n(nmi_n),
        .main_addr(main_addr), .main_wr(main_wr), .main_dout(main_dout),
        .main_din(main_din), .snd_l(snd_l), .snd_r(snd_r),
        .sample(sample), .peak(peak)
    );

    always #50 clk = ~clk;

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [ROM_AW-1:0] exp,
                              input logic [ROM_AW-1:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    // exp is {peak, sample}
    task automatic check_sample(input string name, input logic [16:0] exp,
                                input logic signed [15:0] act, input logic act_peak);
        if (exp !== {act_peak, act}) begin
            $display("FAILED %s: expected %0d peak %b, got %0d peak %b",
                     name, $signed(exp[15:0]), exp[16], act, act_peak);
            errors++;
        end
    endtask

    // all bus tasks start and end on a falling edge
    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        bus = '{addr: a, dout: d, mreq: 1'b1, rfsh: 1'b1, rd: 1'b0, wr: 1'b1};
        @(posedge clk);
        @(negedge clk);
        bus = BUS_IDLE;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d,
                            output logic [ROM_AW-1:0] ra);
        bus = '{addr: a, dout: 8'h00, mreq: 1'b1, rfsh: 1'b1, rd: 1'b1, wr: 1'b0};
        @(posedge clk);
        @(negedge clk);
        d  = cpu_din;
        ra = rom_addr;
        read_cs = rom_cs;
        bus = BUS_IDLE;
    endtask

    function automatic logic [15:0] pcm_addr(input logic [2:0] off);
        return 16'hfc00 | {13'd0, off};
    endfunction

    function automatic logic [7:0] fx_gain(input logic en, input logic [1:0] lvl);
        if (!en) return 8'h00;
        case (lvl)
            2'd0: return FXGAIN_0;
            2'd1: return FXGAIN_1;
            2'd2: return FXGAIN_2;
            default: return FXGAIN_3;
        endcase
    endfunction

    // weighted sum /16, clipped, returned as {peak, sample}
    function automatic logic [16:0] expect_mix(input int fm, input int pcm,
                                               input logic [7:0] gf, input logic [7:0] gx);
        int acc;
        acc = (fm * int'(gf) + pcm * int'(gx)) >>> 4;
        if (acc > 32767) return {1'b1, 16'h7fff};
        if (acc < -32768) return {1'b1, 16'h8000};
        return {1'b0, acc[15:0]};
    endfunction

    task automatic wait_mix(input string name, input logic [16:0] exp_l,
                            input logic [16:0] exp_r, input int limit);
        int n;
        n = 0;
        while ((snd_l !== exp_l[15:0] || snd_r !== exp_r[15:0]) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (n >= limit) begin
            $display("timeout in %s: mixer output never reached the expected value", name);
            errors++;
        end
        check_sample({name, " left"}, exp_l, snd_l, peak);
        check_sample({name, " right"}, exp_r, snd_r, peak);
    endtask

    task automatic test_banking;
        logic [2:0]        bank;
        logic [15:0]       a;
        logic [7:0]        d;
        logic [ROM_AW-1:0] ra;
        for (int i = 0; i < 6; i++) begin
            bank = 3'($random(seed));
            bus_write(16'hfe00, {5'd0, bank});
            a = {1'b1, 15'($random(seed))};
            if (a[15:12] == AF_PAGE) a[12] = 1'b0;   // stay out of the I/O page
            bus_read(a, d, ra);
            check_addr("bank high", {bank, a[13:0]}, ra);
            a = {1'b0, 15'($random(seed))};
            bus_read(a, d, ra);
            check_addr("bank low", {2'b00, a[14:0]}, ra);
        end
    endtask

    task automatic test_read_mux;
        logic [7:0]        d;
        logic [ROM_AW-1:0] ra;
        logic              pol;
        int                n;
        for (int i = 0; i < 4; i++) begin
            rom_data = 8'($random(seed));
            bus_read({1'b0, 15'($random(seed))}, d, ra);
            check_byte("rom read", rom_data, d);
            check_byte("rom cs", 8'h01, {7'd0, read_cs});
            bus_read(16'hf000 | {5'd0, 11'($random(seed))}, d, ra);
            check_byte("ram window", 8'hff, d);
            check_byte("ram cs", 8'h00, {7'd0, read_cs});
        end
        bus_read(16'hfe00, d, ra);
        check_byte("bank read", 8'hff, d);
        // tone status flips every period+1 clocks
        bus_write(16'hf800, 8'd15);
        bus_read(16'hf800, d, ra);
        check_byte("fm status upper", 8'h00, d & 8'hfe);
        pol = d[0];
        n = 0;
        while (d[0] == pol && n < 600) begin
            bus_read(16'hf800, d, ra);
            n++;
        end
        if (n >= 600) begin
            $display("timeout: tone polarity never changed on the fm status read");
            errors++;
        end
        check_byte("sample pulse", 8'h01, {7'd0, sample});   // strobe with the flip
        pol = d[0];
        repeat (15) begin
            bus_read(16'hf800, d, ra);
            check_byte("tone hold", {7'd0, pol}, d);
            check_byte("sample idle", 8'h00, {7'd0, sample});
        end
        bus_read(16'hf800, d, ra);
        check_byte("tone flip", {7'd0, ~pol}, d);
        check_byte("sample pulse", 8'h01, {7'd0, sample});
    endtask

    task automatic test_comm;
        logic [7:0]        d;
        logic [7:0]        v;
        logic [ROM_AW-1:0] ra;
        for (int k = 0; k < 2; k++) begin
            v = 8'($random(seed));
            main_addr = k[0];
            main_dout = v;
            main_wr   = 1'b1;
            @(posedge clk);
            @(negedge clk);
            main_wr = 1'b0;
            bus_read(pcm_addr(k[0] ? PCM_RX1 : PCM_RX0), d, ra);
            check_byte("rx latch", v, d);
            v = 8'($random(seed));
            bus_write(pcm_addr(k[0] ? PCM_TX1 : PCM_TX0), v);
            main_addr = k[0];
            @(negedge clk);
            check_byte("tx latch", v, main_din);
        end
    endtask

    task automatic test_mixing;
        logic signed [7:0] s_l;
        logic signed [7:0] s_r;
        logic [7:0]        gf;
        logic [7:0]        gx;
        bus_write(16'hf801, 8'd0);   // amplitude 0, fm silent
        s_l = 8'($random(seed));
        s_r = 8'($random(seed));
        bus_write(pcm_addr(PCM_L), s_l);
        bus_write(pcm_addr(PCM_R), s_r);
        for (int lvl = 0; lvl < 4; lvl++) begin
            for (int m = 0; m < 4; m++) begin
                enable_fm  = m[0];
                enable_psg = m[1];
                fxlevel    = lvl[1:0];
                gf = enable_fm ? FMGAIN : 8'h00;
                gx = fx_gain(enable_psg, fxlevel);
                wait_mix("pcm mix", expect_mix(0, int'(s_l) * 64, gf, gx),
                         expect_mix(0, int'(s_r) * 64, gf, gx), 10);
            end
        end
        enable_fm  = 1'b1;
        enable_psg = 1'b0;
        bus_write(16'hf801, 8'h40);
        wait_mix("fm high", expect_mix(8'h40 * 128, 0, FMGAIN, 8'h00),
                 expect_mix(8'h40 * 128, 0, FMGAIN, 8'h00), 100);
        wait_mix("fm low", expect_mix(-8'sh40 * 128, 0, FMGAIN, 8'h00),
                 expect_mix(-8'sh40 * 128, 0, FMGAIN, 8'h00), 100);
    endtask

    task automatic test_sat_nmi;
        logic [7:0]        d;
        logic [ROM_AW-1:0] ra;
        logic              smp;
        int                n;
        bus_write(16'hf801, 8'hff);
        bus_write(pcm_addr(PCM_L), 8'd127);
        bus_write(pcm_addr(PCM_R), 8'd127);
        enable_fm  = 1'b1;
        enable_psg = 1'b1;
        fxlevel    = 2'd3;
        wait_mix("saturation", expect_mix(255 * 128, 127 * 64, FMGAIN, FXGAIN_3),
                 expect_mix(255 * 128, 127 * 64, FMGAIN, FXGAIN_3), 100);
        bus_write(16'hf800, 8'd3);   // short period, frequent samples
        bus_read(16'hfa00, d, ra);   // start from a cleared nmi
        check_byte("nmi clear", 8'h01, {7'd0, nmi_n});
        smp = sample;
        n = 0;
        while (nmi_n !== 1'b0 && n < 50) begin
            smp = sample;
            @(negedge clk);
            n++;
        end
        if (n >= 50) begin
            $display("timeout: nmi_n never went low after tone samples");
            errors++;
        end
        check_byte("nmi after sample", 8'h01, {7'd0, smp});   // pulse one clk earlier
        bus_read(16'hfa00, d, ra);
        check_byte("nmi clear again", 8'h01, {7'd0, nmi_n});
    endtask

    initial begin
        seed       = 32'h8987;
        errors     = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        cen        = 1'b1;
        enable_fm  = 1'b0;
        enable_psg = 1'b0;
        fxlevel    = 2'd0;
        bus        = BUS_IDLE;
        rom_data   = 8'h00;
        rom_ok     = 1'b1;
        main_addr  = 1'b0;
        main_wr    = 1'b0;
        main_dout  = 8'h00;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_banking;
        test_read_mux;
        test_comm;
        test_mixing;
        test_sat_nmi;
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/snd_map_pkg.sv
verilog/snd_mix_pkg.sv
verilog/snd_decode.sv
verilog/snd_tone.sv
verilog/snd_pcm.sv
verilog/snd_mixer.sv
verilog/snd_board.sv
sim/snd_board_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sound board testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module snd_board_tb -o snd_sim \
    && ./obj_dir/snd_sim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
